//--- flist.f
hdl/cpu_pkg.sv
hdl/cpu_ctl_if.sv
hdl/op_decode.sv
hdl/seq_fsm.sv
hdl/addr_gen.sv
hdl/reg_bank.sv
hdl/alu8.sv
hdl/status_reg.sv
hdl/cpu_top.sv
tests/tb_cpu.sv
+incdir+hdl

//--- hdl/addr_gen.sv
// Address generator holding the PC and operand latches and driving the memory address bus
`include "cpu_cfg.svh"

module addr_gen import cpu_pkg::*; (
  input  logic  CLK,
  input  logic  R,
  input  data_t mem_rdata,
  cpu_ctl_if.dp ctl,
  output addr_t mem_addr
);

  addr_t pc;
  addr_t prev_addr;
  data_t lo_byte;

  always_comb begin
    case (ctl.st)
      st_lo_byte:
        mem_addr = (ctl.decoded.mode == am_zp) ? {`CPU_ZP_PAGE, mem_rdata} : pc;
      st_hi_byte:    mem_addr = {mem_rdata, lo_byte};
      st_write_data: mem_addr = prev_addr;  // store target
      default:       mem_addr = pc;
    endcase
  end

  always_ff @(posedge CLK or posedge R) begin
    if (R)
      pc <= `CPU_RESET_PC;
    else if (ctl.pc_write)
      pc <= mem_addr + addr_t'(ctl.pc_inc);
    else if (ctl.pc_inc)
      pc <= pc + addr_t'(1);
  end

  always_ff @(posedge CLK) begin
    prev_addr <= mem_addr;
    if (ctl.st == st_lo_byte)
      lo_byte <= mem_rdata;
  end

  // only jmp loads the PC
  a_pc_load: assert property (@(posedge CLK) disable iff (R)
    (ctl.pc_inc && ctl.pc_write) |-> ctl.decoded.cls == ic_jmp);

endmodule

//--- hdl/alu8.sv
// 8-bit ALU for or, and, eor, add and subtract with carry and signed overflow
module alu8 import cpu_pkg::*; (
  alu_if.alu alu
);

  localparam int W = $bits(data_t);

  data_t      b_eff;
  logic [W:0] sum;

  // subtract is a + ~b + cin
  assign b_eff = (alu.op == op_sbc) ? ~alu.b : alu.b;
  assign sum   = {1'b0, alu.a} + {1'b0, b_eff} + (W + 1)'(alu.cin);

  always_comb begin
    case (alu.op)
      op_or:   alu.y = alu.a | alu.b;
      op_and:  alu.y = alu.a & alu.b;
      op_eor:  alu.y = alu.a ^ alu.b;
      default: alu.y = sum[W-1:0];
    endcase
  end

  assign alu.cout = sum[W];
  // same operand signs, different result sign
  assign alu.ovf  = (alu.a[W-1] == b_eff[W-1]) && (sum[W-1] != alu.a[W-1]);

endmodule

//--- hdl/cpu_cfg.svh
// Configuration macros for widths, reset vector and status flag positions of the CPU
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_DW 8  // data bus and register width
`define CPU_AW 16  // address bus width

// first opcode fetch after reset
`define CPU_RESET_PC 16'h0000

`define CPU_ZP_PAGE 8'h00  // high byte for zero-page operands

// bit positions in P
`define P_N 7
`define P_V 6
`define P_Z 1
`define P_C 0

`endif

//--- hdl/cpu_ctl_if.sv
// Interfaces between the sequencer and the datapath, and between operand select and the ALU
interface cpu_ctl_if import cpu_pkg::*; ();

  cpu_state_e st;
  decoded_t   decoded;
  logic       pc_inc;
  logic       pc_write;
  logic       mem_we;

  modport seq (output st, pc_inc, pc_write, mem_we, input decoded);
  modport dec (output decoded, input st);
  modport dp  (input st, decoded, pc_inc, pc_write, mem_we);

endinterface

interface alu_if import cpu_pkg::*; ();

  data_t   a;
  data_t   b;
  logic    cin;
  alu_op_e op;
  data_t   y;
  logic    cout;
  logic    ovf;  // signed overflow

  modport src (output a, b, cin, op, input y);
  modport alu (input a, b, cin, op, output y, cout, ovf);
  modport mon (input y, cout, ovf);

endinterface

//--- hdl/cpu_pkg.sv
// Shared types of the accumulator CPU for states, decode results and ALU operations
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_DW-1:0] data_t;
  typedef logic [`CPU_AW-1:0] addr_t;

  // one-hot, st_initial is all zero
  typedef enum logic [7:0] {
    st_initial    = 8'b0000_0000,
    st_new_op     = 8'b0000_0001,
    st_lo_byte    = 8'b0000_0010,
    st_hi_byte    = 8'b0000_1000,
    st_write_data = 8'b0100_0000,
    st_load_reg   = 8'b1000_0000
  } cpu_state_e;

  typedef enum logic [1:0] {am_implied, am_imm, am_zp, am_abs} amode_e;

  typedef enum logic [1:0] {sel_a, sel_x, sel_y} reg_sel_e;

  typedef enum logic [3:0] {
    ic_load, ic_store, ic_logic, ic_adc, ic_sbc, ic_cmp,
    ic_inc, ic_dec, ic_trans, ic_flag, ic_jmp, ic_nop
  } instr_e;

  typedef enum logic [2:0] {op_or, op_and, op_eor, op_adc, op_sbc} alu_op_e;

  typedef struct packed {
    instr_e   cls;
    amode_e   mode;
    reg_sel_e dst;   // load, store and write-back register
    reg_sel_e src;   // transfer source
    logic     fval;  // new C for clc/sec
    alu_op_e  lop;   // or/and/eor for logic ops
  } decoded_t;

endpackage

//--- hdl/cpu_top.sv
// Top level of the accumulator CPU with ports to an external synchronous memory
module cpu_top (
  input  logic        CLK,
  input  logic        R,
  output logic [15:0] mem_addr,
  input  logic [7:0]  mem_rdata,
  output logic [7:0]  mem_wdata,
  output logic        mem_we,
  output logic        instr_start,
  output logic [7:0]  reg_a,
  output logic [7:0]  reg_x,
  output logic [7:0]  reg_y,
  output logic [7:0]  reg_p
);

  cpu_ctl_if ctl ();
  alu_if     alu ();

  logic carry;

  op_decode u_op_decode (
    .CLK(CLK),
    .R(R),
    .mem_rdata(mem_rdata),
    .ctl(ctl.dec)
  );

  seq_fsm u_seq_fsm (
    .CLK(CLK),
    .R(R),
    .ctl(ctl.seq)
  );

  addr_gen u_addr_gen (
    .CLK(CLK),
    .R(R),
    .mem_rdata(mem_rdata),
    .ctl(ctl.dp),
    .mem_addr(mem_addr)
  );

  reg_bank u_reg_bank (
    .CLK(CLK),
    .R(R),
    .mem_rdata(mem_rdata),
    .ctl(ctl.dp),
    .carry(carry),
    .alu(alu.src),
    .mem_wdata(mem_wdata),
    .reg_a(reg_a),
    .reg_x(reg_x),
    .reg_y(reg_y)
  );

  alu8 u_alu8 (
    .alu(alu.alu)
  );

  status_reg u_status_reg (
    .CLK(CLK),
    .R(R),
    .ctl(ctl.dp),
    .alu(alu.mon),
    .reg_p(reg_p),
    .carry(carry)
  );

  assign mem_we      = ctl.mem_we;
  assign instr_start = (ctl.st == cpu_pkg::st_new_op);  // opcode on mem_rdata

endmodule

//--- hdl/op_decode.sv
// Opcode decoder holding the opcode register and splitting it into class, mode and register
module op_decode import cpu_pkg::*; (
  input  logic   CLK,
  input  logic   R,
  input  data_t  mem_rdata,
  cpu_ctl_if.dec ctl
);

  localparam logic [1:0] grp8 = 2'b01;  // ora..sbc, lda, sta
  localparam logic [1:0] grp6 = 2'b10;  // ldx, stx
  localparam logic [1:0] grp5 = 2'b00;  // ldy, sty

  data_t      op_q;
  data_t      op;
  logic [3:0] op_hi;
  logic [3:0] op_lo;
  logic [2:0] aaa;
  logic [2:0] iax;
  logic [1:0] grp;
  logic [2:0] imm_code;
  logic       mode_ok;
  amode_e     mode;
  decoded_t   d;

  always_ff @(posedge CLK or posedge R) begin
    if (R)
      op_q <= 8'hEA;  // nop
    else if (ctl.st == st_new_op)
      op_q <= mem_rdata;
  end

  // opcode is still on the bus in st_new_op
  assign op    = (ctl.st == st_new_op) ? mem_rdata : op_q;
  assign op_hi = op[7:4];
  assign op_lo = op[3:0];
  assign aaa   = op[7:5];
  assign iax   = op[4:2];
  assign grp   = op[1:0];

  // group 8 takes immediate at iax 010, groups 6 and 5 at 000
  assign imm_code = (grp == grp8) ? 3'b010 : 3'b000;
  assign mode_ok  = (grp != 2'b11) && (iax == 3'b001 || iax == 3'b011 || iax == imm_code);
  assign mode     = (iax == 3'b001) ? am_zp : (iax == 3'b011) ? am_abs : am_imm;

  always_comb begin
    d.cls  = ic_nop;
    d.mode = mode;
    d.dst  = (grp == grp6) ? sel_x : (grp == grp5) ? sel_y : sel_a;
    d.src  = sel_a;
    d.fval = op_hi[1];  // 0x18 clc, 0x38 sec
    d.lop  = (aaa == 3'b000) ? op_or : (aaa == 3'b001) ? op_and : op_eor;
    if (op_lo == 4'h8) begin
      case (op_hi)
        4'h1, 4'h3: d.cls = ic_flag;
        4'h8: d.cls = ic_dec;     // dey
        4'h9: begin               // tya
          d.cls = ic_trans;
          d.dst = sel_a;
          d.src = sel_y;
        end
        4'hA: d.cls = ic_trans;   // tay
        4'hC: d.cls = ic_inc;     // iny
        4'hE: begin               // inx
          d.cls = ic_inc;
          d.dst = sel_x;
        end
        default: d.cls = ic_nop;  // stack and dropped flag ops
      endcase
    end else if (op_lo == 4'hA) begin
      case (op_hi)
        4'h8: begin               // txa
          d.cls = ic_trans;
          d.dst = sel_a;
          d.src = sel_x;
        end
        4'hA: d.cls = ic_trans;   // tax
        4'hC: d.cls = ic_dec;     // dex
        default: d.cls = ic_nop;
      endcase
    end else if (op == 8'h4C) begin
      d.cls = ic_jmp;
    end else if (mode_ok) begin
      case (aaa)
        3'b000, 3'b001, 3'b010: d.cls = ic_logic;
        3'b011: d.cls = ic_adc;
        3'b100: d.cls = (mode == am_imm) ? ic_nop : ic_store;
        3'b101: d.cls = ic_load;
        3'b110: d.cls = ic_cmp;
        default: d.cls = ic_sbc;
      endcase
      if (grp != grp8 && aaa != 3'b100 && aaa != 3'b101)
        d.cls = ic_nop;  // cpx, cpy, bit, shifts, inc/dec mem
    end
    if (d.cls inside {ic_nop, ic_flag, ic_trans, ic_inc, ic_dec})
      d.mode = am_implied;
  end

  assign ctl.decoded = d;

endmodule

//--- hdl/reg_bank.sv
// Register bank with A, X and Y, ALU operand selection and store data
module reg_bank import cpu_pkg::*; (
  input  logic  CLK,
  input  logic  R,
  input  data_t mem_rdata,
  cpu_ctl_if.dp ctl,
  input  logic  carry,
  alu_if.src    alu,
  output data_t mem_wdata,
  output data_t reg_a,
  output data_t reg_x,
  output data_t reg_y
);

  decoded_t d;
  data_t    dst_val;
  data_t    src_val;
  logic     wr_en;

  function automatic data_t pick(reg_sel_e s, data_t a, data_t x, data_t y);
    case (s)
      sel_x:   return x;
      sel_y:   return y;
      default: return a;
    endcase
  endfunction

  assign d         = ctl.decoded;
  assign dst_val   = pick(d.dst, reg_a, reg_x, reg_y);
  assign src_val   = pick(d.src, reg_a, reg_x, reg_y);
  assign mem_wdata = dst_val;

  always_comb begin
    alu.a   = dst_val;
    alu.b   = mem_rdata;
    alu.cin = carry;
    alu.op  = op_adc;
    case (d.cls)
      ic_load, ic_trans: begin  // value + 0
        alu.a   = (d.cls == ic_load) ? mem_rdata : src_val;
        alu.b   = '0;
        alu.cin = 1'b0;
      end
      ic_inc, ic_dec: begin
        alu.b   = '0;
        alu.cin = (d.cls == ic_inc);  // r + 0 + 1, or r + ff + 0
        alu.op  = (d.cls == ic_inc) ? op_adc : op_sbc;
      end
      ic_logic: alu.op = d.lop;
      ic_sbc:   alu.op = op_sbc;
      ic_cmp: begin
        alu.op  = op_sbc;
        alu.cin = 1'b1;  // plain a - m
      end
      default: ;
    endcase
  end

  assign wr_en = (ctl.st == st_load_reg) &&
                 (d.cls inside {ic_load, ic_trans, ic_inc, ic_dec, ic_logic, ic_adc, ic_sbc});

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      reg_a <= '0;
      reg_x <= '0;
      reg_y <= '0;
    end else if (wr_en) begin
      case (d.dst)
        sel_x:   reg_x <= alu.y;
        sel_y:   reg_y <= alu.y;
        default: reg_a <= alu.y;
      endcase
    end
  end

endmodule

//--- hdl/seq_fsm.sv
// One-hot instruction sequencer driving the PC controls and the memory write strobe
module seq_fsm import cpu_pkg::*; (
  input  logic   CLK,
  input  logic   R,
  cpu_ctl_if.seq ctl
);

  cpu_state_e st_nxt;
  cpu_state_e st_mem;
  instr_e     cls;
  amode_e     mode;
  logic       implied_reg;

  assign cls         = ctl.decoded.cls;
  assign mode        = ctl.decoded.mode;
  assign implied_reg = cls inside {ic_trans, ic_inc, ic_dec};
  assign st_mem      = (cls == ic_store) ? st_write_data : st_load_reg;  // once address is known

  always_comb begin
    case (ctl.st)
      st_initial: st_nxt = st_new_op;
      st_new_op: begin
        if (cls inside {ic_flag, ic_nop})
          st_nxt = st_new_op;
        else if (implied_reg || mode == am_imm)
          st_nxt = st_load_reg;
        else
          st_nxt = st_lo_byte;
      end
      st_lo_byte: st_nxt = (mode == am_zp) ? st_mem : st_hi_byte;
      st_hi_byte: st_nxt = (cls == ic_jmp) ? st_new_op : st_mem;
      st_write_data: st_nxt = st_load_reg;
      default: st_nxt = st_new_op;  // st_load_reg
    endcase
  end

  always_ff @(posedge CLK or posedge R) begin
    if (R)
      ctl.st <= st_initial;
    else
      ctl.st <= st_nxt;
  end

  // advance past every opcode or operand byte shown on the bus
  always_comb begin
    case (ctl.st)
      st_initial, st_load_reg: ctl.pc_inc = 1'b1;
      st_new_op:  ctl.pc_inc = !implied_reg;
      st_lo_byte: ctl.pc_inc = (mode == am_abs);
      st_hi_byte: ctl.pc_inc = (cls == ic_jmp);  // target + 1, opcode comes next
      default:    ctl.pc_inc = 1'b0;
    endcase
  end

  assign ctl.pc_write = (ctl.st == st_hi_byte) && (cls == ic_jmp);
  assign ctl.mem_we   = (ctl.st == st_write_data);

  // st_initial only right out of reset
  a_onehot: assert property (@(posedge CLK) disable iff (R)
    $onehot(ctl.st) || (ctl.st == st_initial && $past(ctl.st) == st_initial));

endmodule

//--- hdl/status_reg.sv
// Status register P with N, V, Z and C updates per instruction class
`include "cpu_cfg.svh"

module status_reg import cpu_pkg::*; (
  input  logic  CLK,
  input  logic  R,
  cpu_ctl_if.dp ctl,
  alu_if.mon    alu,
  output data_t reg_p,
  output logic  carry
);

  decoded_t d;
  logic     upd_nz;

  assign d      = ctl.decoded;
  assign carry  = reg_p[`P_C];
  assign upd_nz = (ctl.st == st_load_reg) &&
                  (d.cls inside {ic_load, ic_trans, ic_inc, ic_dec,
                                 ic_logic, ic_adc, ic_sbc, ic_cmp});

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      reg_p <= 8'h20;  // bit 5 reads as 1
    end else if (ctl.st == st_new_op && d.cls == ic_flag) begin
      reg_p[`P_C] <= d.fval;
    end else if (upd_nz) begin
      reg_p[`P_N] <= alu.y[`CPU_DW-1];
      reg_p[`P_Z] <= (alu.y == '0);
      if (d.cls inside {ic_adc, ic_sbc, ic_cmp})
        reg_p[`P_C] <= alu.cout;
      if (d.cls inside {ic_adc, ic_sbc})
        reg_p[`P_V] <= alu.ovf;
    end
  end

  a_store_keeps_p: assert property (@(posedge CLK) disable iff (R)
    (d.cls == ic_store && ctl.st != st_initial) |=> $stable(reg_p));

endmodule

//--- run.sh
#!/bin/sh
# builds the CPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f flist.f --top-module tb_cpu --Mdir obj_dir -o sim_tb_cpu > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

//--- tests/tb_cpu.sv
// Testbench for the accumulator CPU with random program, reference model and checks
`include "cpu_cfg.svh"

module tb_cpu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [7:0] OPS [0:43] = '{
    8'hA9, 8'hA5, 8'hAD, 8'hA2, 8'hA6, 8'hAE, 8'hA0, 8'hA4, 8'hAC,
    8'h85, 8'h8D, 8'h86, 8'h8E, 8'h84, 8'h8C,
    8'h09, 8'h05, 8'h0D, 8'h29, 8'h25, 8'h2D, 8'h49, 8'h45, 8'h4D,
    8'h69, 8'h65, 8'h6D, 8'hE9, 8'hE5, 8'hED, 8'hC9, 8'hC5, 8'hCD,
    8'hAA, 8'h8A, 8'hA8, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88,
    8'h18, 8'h38, 8'hEA
  };

  logic        CLK;
  logic        R;
  logic [15:0] mem_addr;
  logic [7:0]  mem_rdata;
  logic [7:0]  mem_wdata;
  logic        mem_we;
  logic        instr_start;
  logic [7:0]  reg_a, reg_x, reg_y, reg_p;

  logic [7:0]  mem [0:65535];
  logic [7:0]  ref_mem [0:65535];
  logic [15:0] rd_addr;
  logic [15:0] prev_addr;
  logic [31:0] lfsr = 32'h4f98_e7d5;

  // reference state, results of all instructions before the current one
  logic [7:0]  m_a = 8'h00;
  logic [7:0]  m_x = 8'h00;
  logic [7:0]  m_y = 8'h00;
  logic [7:0]  m_p = 8'h20;
  logic [15:0] m_pc = `CPU_RESET_PC;
  logic        we_pending = 1'b0;
  logic [15:0] exp_waddr;
  logic [7:0]  exp_wdata;
  int          last_cls = 4;
  int          cnt_cls [0:4] = '{0, 0, 0, 0, 0};
  int          err_cnt [0:4] = '{0, 0, 0, 0, 0};
  int          self_hits = 0;
  int          n_instr = 0;
  bit          gen_done = 0;

  cpu_top u_cpu_top (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // synchronous read, data handed over on the falling edge
  always @(posedge CLK) begin
    if (mem_we)
      mem[mem_addr] <= mem_wdata;
    rd_addr   <= mem_addr;
    prev_addr <= mem_addr;
  end

  always @(negedge CLK)
    mem_rdata <= mem[rd_addr];

  function automatic logic [7:0] rand_bits(int n);
    logic [7:0] r;
    logic       fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[6:0], fb};
    end
    return r;
  endfunction

  // 0 implied, 1 imm, 2 zp, 3 abs, 4 jmp
  function automatic int op_mode(logic [7:0] op);
    if (op == 8'h4C)
      return 4;
    if (op[3:0] == 4'h8 || op[3:0] == 4'hA)
      return 0;
    if (op[3:0] == 4'h9 || op == 8'hA0 || op == 8'hA2)
      return 1;
    if (op[3:2] == 2'b01)
      return 2;
    return 3;
  endfunction

  function automatic logic [7:0] set_nz(logic [7:0] p, logic [7:0] v);
    p[`P_N] = v[7];
    p[`P_Z] = (v == 8'h00);
    return p;
  endfunction

  task automatic put_byte(logic [15:0] a, logic [7:0] b);
    mem[a]     = b;
    ref_mem[a] = b;
  endtask

  task automatic build_program();
    logic [15:0] pc;
    logic [15:0] tgt;
    logic [7:0]  op;
    int          md;
    pc = `CPU_RESET_PC;
    while (pc < 16'h0068) begin
      n_instr++;
      if (rand_bits(4) == 8'h0) begin  // forward jump over junk
        tgt = pc + 16'd3 + 16'(rand_bits(2));
        put_byte(pc, 8'h4C);
        put_byte(pc + 16'd1, tgt[7:0]);
        put_byte(pc + 16'd2, tgt[15:8]);
        pc = tgt;
      end else begin
        op = OPS[rand_bits(8) % 44];
        md = op_mode(op);
        put_byte(pc, op);
        if (md == 1)
          put_byte(pc + 16'd1, rand_bits(8));
        if (md == 2)
          put_byte(pc + 16'd1, 8'h80 | rand_bits(7));  // clear of the program
        if (md == 3) begin
          put_byte(pc + 16'd1, rand_bits(8));
          put_byte(pc + 16'd2, 8'h40 | rand_bits(4));
        end
        pc = pc + 16'((md == 0) ? 1 : (md == 3) ? 3 : 2);
      end
    end
    put_byte(pc, 8'h4C);  // jump to itself
    put_byte(pc + 16'd1, pc[7:0]);
    put_byte(pc + 16'd2, pc[15:8]);
  endtask

  always @(posedge CLK) begin : ref_model
    logic [7:0]  op, b1, b2, v, bb, na, nx, ny, np;
    logic [8:0]  s;
    logic [15:0] ea, npc;
    int          md, cls;
    int          sv;
    if (R)
      cnt_cls[0] <= cnt_cls[0] + 1;
    if (mem_we)
      we_pending <= 1'b0;
    if (!R && instr_start) begin
      op  = ref_mem[m_pc];
      b1  = ref_mem[m_pc + 16'd1];
      b2  = ref_mem[m_pc + 16'd2];
      md  = op_mode(op);
      ea  = (md == 2) ? {`CPU_ZP_PAGE, b1} : {b2, b1};
      v   = (md == 1) ? b1 : ref_mem[ea];
      npc = m_pc + 16'((md == 0) ? 1 : (md == 1 || md == 2) ? 2 : 3);
      na  = m_a;
      nx  = m_x;
      ny  = m_y;
      np  = m_p;
      cls = 1;
      case (op)
        8'hA9, 8'hA5, 8'hAD: na = v;
        8'hA2, 8'hA6, 8'hAE: nx = v;
        8'hA0, 8'hA4, 8'hAC: ny = v;
        8'h09, 8'h05, 8'h0D: na = m_a | v;
        8'h29, 8'h25, 8'h2D: na = m_a & v;
        8'h49, 8'h45, 8'h4D: na = m_a ^ v;
        8'hAA: nx = m_a;
        8'h8A: na = m_x;
        8'hA8: ny = m_a;
        8'h98: na = m_y;
        8'hE8: nx = m_x + 8'd1;
        8'hC8: ny = m_y + 8'd1;
        8'hCA: nx = m_x - 8'd1;
        8'h88: ny = m_y - 8'd1;
        default: ;
      endcase
      if (op[3:0] inside {4'h9, 4'h5, 4'hD} && op != 8'hA9 && op != 8'hA5 && op != 8'hAD)
        cls = 2;
      if (op[7:5] == 3'd4 && md >= 2)  // stores
        cls = 3;
      if (op inside {8'h18, 8'h38, 8'hEA, 8'h4C})
        cls = 4;
      if (cls == 1)
        np = set_nz(np, (op inside {8'hA2, 8'hA6, 8'hAE, 8'hAA, 8'hE8, 8'hCA}) ? nx :
                        (op inside {8'hA0, 8'hA4, 8'hAC, 8'hA8, 8'hC8, 8'h88}) ? ny : na);
      if (cls == 2 && op[7:5] < 3'd3)
        np = set_nz(np, na);
      if (cls == 2 && op[7:5] inside {3'd3, 3'd6, 3'd7}) begin  // adc, cmp, sbc
        bb = (op[7]) ? ~v : v;
        s  = {1'b0, m_a} + {1'b0, bb} + 9'((op[7:5] == 3'd6) ? 1'b1 : m_p[`P_C]);
        np = set_nz(np, s[7:0]);
        np[`P_C] = s[8];
        if (op[7:5] != 3'd6) begin
          // signed result outside -128..127
          sv = (op[7]) ? int'($signed(m_a)) - int'($signed(v)) - int'(!m_p[`P_C]) :
                         int'($signed(m_a)) + int'($signed(v)) + int'(m_p[`P_C]);
          np[`P_V] = (sv > 127 || sv < -128);
          na = s[7:0];
        end
      end
      if (cls == 3) begin
        we_pending <= 1'b1;
        exp_waddr  <= ea;
        exp_wdata  <= (op[1:0] == 2'b10) ? m_x : (op[1:0] == 2'b00) ? m_y : m_a;
        ref_mem[ea] <= (op[1:0] == 2'b10) ? m_x : (op[1:0] == 2'b00) ? m_y : m_a;
      end
      if (op == 8'h18 || op == 8'h38)
        np[`P_C] = op[5];
      if (op == 8'h4C) begin
        npc = {b2, b1};
        if (npc == m_pc)
          self_hits <= self_hits + 1;
      end
      m_a  <= na;
      m_x  <= nx;
      m_y  <= ny;
      m_p  <= np;
      m_pc <= npc;
      last_cls <= cls;
      cnt_cls[cls] <= cnt_cls[cls] + 1;
    end
  end

  a_reset: assert property (@(posedge CLK) (R || $fell(R)) |->
    (!instr_start && !mem_we && mem_addr == `CPU_RESET_PC))
    else begin
      err_cnt[0]++;
      $display("error %0t: strobe or address wrong around reset, addr %h", $time, mem_addr);
    end

  a_state: assert property (@(posedge CLK) disable iff (R) instr_start |->
    (reg_a == m_a && reg_x == m_x && reg_y == m_y && reg_p == m_p))
    else begin
      err_cnt[last_cls]++;
      $display("error %0t: a/x/y/p %h %h %h %h, expected %h %h %h %h", $time,
               reg_a, reg_x, reg_y, reg_p, m_a, m_x, m_y, m_p);
    end

  a_fetch: assert property (@(posedge CLK) disable iff (R) instr_start |-> prev_addr == m_pc)
    else begin
      err_cnt[4]++;
      $display("error %0t: opcode fetched at %h, expected %h", $time, prev_addr, m_pc);
    end

  a_write: assert property (@(posedge CLK) disable iff (R) mem_we |->
    (we_pending && mem_addr == exp_waddr && mem_wdata == exp_wdata))
    else begin
      err_cnt[3]++;
      $display("error %0t: write %h to %h, expected %h to %h (pending %b)", $time,
               mem_wdata, mem_addr, exp_wdata, exp_waddr, we_pending);
    end

  a_one_write: assert property (@(posedge CLK) disable iff (R) instr_start |-> !we_pending)
    else begin
      err_cnt[3]++;
      $display("error %0t: store finished without a write pulse", $time);
    end

  // watchdog, 6 cycles of 4 ns per instruction plus margin
  initial begin
    wait (gen_done);
    #((n_instr + 20) * 6 * 4 + 400);
    $display("timeout: self-jump loop never reached after %0d instructions", n_instr);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    string names [0:4];
    int    total;
    names = '{"reset", "load/transfer/inc/dec", "alu ops", "stores", "flags/jmp/nop"};
    total = 0;
    R = 1'b1;
    mem_rdata = 8'h00;
    for (int i = 0; i < 65536; i++) begin
      mem[i]     = i[7:0] ^ (i[15:8] * 8'h5b);
      ref_mem[i] = mem[i];
    end
    build_program();
    gen_done = 1;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    R = 1'b0;
    wait (self_hits >= 3);
    repeat (6) @(posedge CLK);
    @(negedge CLK);
    for (int k = 0; k < 5; k++) begin
      $display("test %s: %0d checked, %0d errors", names[k], cnt_cls[k], err_cnt[k]);
      if (cnt_cls[k] == 0) begin
        $display("test %s was never exercised by the program", names[k]);
        total++;
      end
      total += err_cnt[k];
    end
    $display("%0d instructions, %0d failures", n_instr, total);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
